// File: design/mcu_defs.svh
// MCU subsystem constants
// Data and address widths, SRAM depth, APB address map and core vectors

`ifndef MCU_DEFS_SVH
`define MCU_DEFS_SVH

`define MCU_DATA_W      32
`define MCU_ADDR_W      32
`define MCU_MEM_WORDS   64

// APB map as seen by the host
`define MCU_IRAM_BASE   (32'h0000_0000)
`define MCU_DRAM_BASE   (32'h0000_0100)
`define MCU_CTRL_ADDR   (32'h0000_0200)

// Core fetch addresses
`define MCU_BOOT_ADDR   (32'h0000_0000)
`define MCU_IRQ_VECTOR  (32'h0000_0080)

`endif

// File: design/mcu_pkg.sv
// MCU shared types
// OBI request/response structs and the accumulator core instruction format

`include "mcu_defs.svh"

package mcu_pkg;

    typedef struct packed {
        logic                     req;
        logic                     we;
        logic [`MCU_DATA_W/8-1:0] be;
        logic [`MCU_ADDR_W-1:0]   addr;
        logic [`MCU_DATA_W-1:0]   wdata;
    } obi_req_t;

    typedef struct packed {
        logic                   gnt;
        logic                   rvalid;
        logic [`MCU_DATA_W-1:0] rdata;
    } obi_resp_t;

    // Encoding 0 is left unused so a cleared word decodes as a no-op
    typedef enum logic [3:0] {
        LDI  = 4'h1,
        LD   = 4'h2,
        ST   = 4'h3,
        ADD  = 4'h4,
        DEC  = 4'h5,
        BNZ  = 4'h6,
        HALT = 4'h7,
        RETI = 4'h8
    } opcode_e;

    typedef struct packed {
        opcode_e     opcode;
        logic [3:0]  pad;
        logic [23:0] operand;
    } instr_t;

endpackage

// File: design/acc_core.sv
// Accumulator core
// Multi-cycle FSM with OBI instruction and data ports, one interrupt level and sleep

`timescale 1ns/1ns
`include "mcu_defs.svh"

module acc_core (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               fetch_en_i,
    output mcu_pkg::obi_req_t  instr_req_o,
    input  mcu_pkg::obi_resp_t instr_resp_i,
    output mcu_pkg::obi_req_t  data_req_o,
    input  mcu_pkg::obi_resp_t data_resp_i,
    input  logic               irq_i,
    output logic               irq_ack_o,
    output logic               core_sleep_o
);

    typedef enum logic [2:0] {
        S_FETCH,
        S_WAIT_I,
        S_EXEC,
        S_WAIT_D,
        S_SLEEP,
        S_IRQ
    } state_e;

    state_e                 state_q;
    state_e                 state_d;
    state_e                 boundary_st;
    logic [`MCU_ADDR_W-1:0] pc_q;
    logic [`MCU_ADDR_W-1:0] pc_d;
    logic [`MCU_ADDR_W-1:0] epc_q;
    logic [`MCU_ADDR_W-1:0] epc_d;
    logic [`MCU_ADDR_W-1:0] pc_next;
    logic [`MCU_ADDR_W-1:0] operand_addr;
    logic [`MCU_DATA_W-1:0] acc_q;
    logic [`MCU_DATA_W-1:0] acc_d;
    logic                   in_irq_q;
    logic                   in_irq_d;
    logic                   irq_take;
    logic                   mem_op;
    mcu_pkg::instr_t        instr_q;

    assign pc_next      = pc_q + `MCU_ADDR_W'(4);
    assign operand_addr = {{(`MCU_ADDR_W-24){1'b0}}, instr_q.operand};
    assign mem_op       = instr_q.opcode inside {mcu_pkg::LD, mcu_pkg::ST, mcu_pkg::ADD};
    assign irq_take     = irq_i && !in_irq_q;
    // Where to go once an instruction retires
    assign boundary_st  = irq_take ? S_IRQ : S_FETCH;

    always_comb begin
        state_d  = state_q;
        pc_d     = pc_q;
        epc_d    = epc_q;
        acc_d    = acc_q;
        in_irq_d = in_irq_q;
        case (state_q)
            S_FETCH: begin
                if (instr_resp_i.gnt) begin
                    state_d = S_WAIT_I;
                end
            end
            S_WAIT_I: begin
                if (instr_resp_i.rvalid) begin
                    state_d = S_EXEC;
                end
            end
            S_EXEC: begin
                case (instr_q.opcode)
                    mcu_pkg::LDI: begin
                        acc_d   = {{(`MCU_DATA_W-24){1'b0}}, instr_q.operand};
                        pc_d    = pc_next;
                        state_d = boundary_st;
                    end
                    mcu_pkg::LD, mcu_pkg::ST, mcu_pkg::ADD: begin
                        // Request held here until the SRAM grants it
                        if (data_resp_i.gnt) begin
                            state_d = S_WAIT_D;
                        end
                    end
                    mcu_pkg::DEC: begin
                        acc_d   = acc_q - `MCU_DATA_W'(1);
                        pc_d    = pc_next;
                        state_d = boundary_st;
                    end
                    mcu_pkg::BNZ: begin
                        pc_d    = (acc_q != '0) ? operand_addr : pc_next;
                        state_d = boundary_st;
                    end
                    mcu_pkg::HALT: begin
                        pc_d    = pc_next;
                        state_d = S_SLEEP;
                    end
                    mcu_pkg::RETI: begin
                        pc_d     = epc_q;
                        in_irq_d = 1'b0;
                        state_d  = S_FETCH;
                    end
                    default: begin
                        pc_d    = pc_next;
                        state_d = boundary_st;
                    end
                endcase
            end
            S_WAIT_D: begin
                if (data_resp_i.rvalid) begin
                    if (instr_q.opcode == mcu_pkg::LD) begin
                        acc_d = data_resp_i.rdata;
                    end else if (instr_q.opcode == mcu_pkg::ADD) begin
                        acc_d = acc_q + data_resp_i.rdata;
                    end
                    pc_d    = pc_next;
                    state_d = boundary_st;
                end
            end
            S_SLEEP: begin
                if (irq_take) begin
                    state_d = S_IRQ;
                end
            end
            S_IRQ: begin
                // pc already points past the last retired instruction
                epc_d    = pc_q;
                pc_d     = `MCU_IRQ_VECTOR;
                in_irq_d = 1'b1;
                state_d  = S_FETCH;
            end
            default: state_d = S_FETCH;
        endcase
    end

    // Stopped core sits in its reset state
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !fetch_en_i) begin
            state_q  <= S_FETCH;
            pc_q     <= `MCU_BOOT_ADDR;
            epc_q    <= '0;
            acc_q    <= '0;
            in_irq_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            pc_q     <= pc_d;
            epc_q    <= epc_d;
            acc_q    <= acc_d;
            in_irq_q <= in_irq_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == S_WAIT_I && instr_resp_i.rvalid) begin
            instr_q <= mcu_pkg::instr_t'(instr_resp_i.rdata);
        end
    end

    assign instr_req_o.req   = fetch_en_i && (state_q == S_FETCH);
    assign instr_req_o.we    = 1'b0;
    assign instr_req_o.be    = '1;
    assign instr_req_o.addr  = pc_q;
    assign instr_req_o.wdata = '0;

    assign data_req_o.req    = fetch_en_i && (state_q == S_EXEC) && mem_op;
    assign data_req_o.we     = (instr_q.opcode == mcu_pkg::ST);
    assign data_req_o.be     = '1;
    assign data_req_o.addr   = operand_addr;
    assign data_req_o.wdata  = acc_q;

    assign irq_ack_o    = (state_q == S_IRQ);
    assign core_sleep_o = (state_q == S_SLEEP);

    // OBI handshake rules on both ports
    a_instr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i || !fetch_en_i)
        instr_req_o.req && !instr_resp_i.gnt |=> instr_req_o.req && $stable(instr_req_o));
    a_data_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i || !fetch_en_i)
        data_req_o.req && !data_resp_i.gnt |=> data_req_o.req && $stable(data_req_o));
    a_instr_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_resp_i.rvalid |-> $past(instr_req_o.req && instr_resp_i.gnt));
    a_data_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_resp_i.rvalid |-> $past(data_req_o.req && data_resp_i.gnt));

endmodule

// File: design/cpu_subsystem.sv
// CPU subsystem
// Wraps the accumulator core and encodes the interrupt vector into id and acknowledge

`timescale 1ns/1ns

module cpu_subsystem (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               fetch_en_i,
    output mcu_pkg::obi_req_t  core_instr_req_o,
    input  mcu_pkg::obi_resp_t core_instr_resp_i,
    output mcu_pkg::obi_req_t  core_data_req_o,
    input  mcu_pkg::obi_resp_t core_data_resp_i,
    input  logic [31:0]        irq_i,
    output logic               irq_ack_o,
    output logic [ 4:0]        irq_id_o,
    output logic               core_sleep_o
);

    mcu_pkg::obi_req_t instr_req;
    logic              irq_any;
    logic [4:0]        irq_id_enc;
    logic [4:0]        irq_id_q;

    // Instruction port is read only
    assign core_instr_req_o.req   = instr_req.req;
    assign core_instr_req_o.addr  = instr_req.addr;
    assign core_instr_req_o.we    = 1'b0;
    assign core_instr_req_o.be    = 4'b1111;
    assign core_instr_req_o.wdata = '0;

    assign irq_any = |irq_i;

    // Lowest set index wins
    always_comb begin
        irq_id_enc = '0;
        for (int i = 31; i >= 0; i--) begin
            if (irq_i[i]) begin
                irq_id_enc = 5'(i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            irq_id_q <= '0;
        end else if (irq_ack_o) begin
            irq_id_q <= irq_id_enc;
        end
    end

    // Live id during the ack cycle, held copy afterwards
    assign irq_id_o = irq_ack_o ? irq_id_enc : irq_id_q;

    acc_core i_core (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .fetch_en_i  (fetch_en_i),
        .instr_req_o (instr_req),
        .instr_resp_i(core_instr_resp_i),
        .data_req_o  (core_data_req_o),
        .data_resp_i (core_data_resp_i),
        .irq_i       (irq_any),
        .irq_ack_o   (irq_ack_o),
        .core_sleep_o(core_sleep_o)
    );

endmodule

// File: design/obi_sram.sv
// Dual-port OBI word SRAM
// Host port has fixed priority over the core port, one cycle read latency

`timescale 1ns/1ns
`include "mcu_defs.svh"

module obi_sram (
    input  logic               clk_i,
    input  mcu_pkg::obi_req_t  host_req_i,
    output mcu_pkg::obi_resp_t host_resp_o,
    input  mcu_pkg::obi_req_t  core_req_i,
    output mcu_pkg::obi_resp_t core_resp_o
);

    localparam int unsigned AW = $clog2(`MCU_MEM_WORDS);

    logic [`MCU_DATA_W-1:0] mem [`MCU_MEM_WORDS];
    logic [`MCU_DATA_W-1:0] rdata_q;
    logic                   host_gnt;
    logic                   core_gnt;
    logic                   host_rvalid_q;
    logic                   core_rvalid_q;
    mcu_pkg::obi_req_t      sel_req;
    logic [AW-1:0]          word_idx;

    // Core waits whenever the host is active
    assign host_gnt = host_req_i.req;
    assign core_gnt = core_req_i.req && !host_req_i.req;
    assign sel_req  = host_gnt ? host_req_i : core_req_i;
    assign word_idx = sel_req.addr[AW+1:2];

    always_ff @(posedge clk_i) begin
        if (host_gnt || core_gnt) begin
            if (sel_req.we) begin
                for (int b = 0; b < `MCU_DATA_W/8; b++) begin
                    if (sel_req.be[b]) begin
                        mem[word_idx][8*b +: 8] <= sel_req.wdata[8*b +: 8];
                    end
                end
            end
            // Old contents on a write
            rdata_q <= mem[word_idx];
        end
        host_rvalid_q <= host_gnt;
        core_rvalid_q <= core_gnt;
    end

    assign host_resp_o.gnt    = host_gnt;
    assign host_resp_o.rvalid = host_rvalid_q;
    assign host_resp_o.rdata  = rdata_q;
    assign core_resp_o.gnt    = core_gnt;
    assign core_resp_o.rvalid = core_rvalid_q;
    assign core_resp_o.rdata  = rdata_q;

    // Never both ports granted in one cycle
    a_one_grant: assert property (@(posedge clk_i)
        !(host_resp_o.gnt && core_resp_o.gnt));

endmodule

// File: design/apb_mem_bridge.sv
// APB to OBI bridge
// Host access to both SRAMs plus the fetch enable control register

`timescale 1ns/1ns
`include "mcu_defs.svh"

module apb_mem_bridge (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [`MCU_ADDR_W-1:0] paddr_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [`MCU_DATA_W-1:0] pwdata_i,
    output logic [`MCU_DATA_W-1:0] prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    output mcu_pkg::obi_req_t      iram_req_o,
    input  mcu_pkg::obi_resp_t     iram_resp_i,
    output mcu_pkg::obi_req_t      dram_req_o,
    input  mcu_pkg::obi_resp_t     dram_resp_i,
    output logic                   fetch_en_o
);

    localparam logic [`MCU_ADDR_W-1:0] REGION_BYTES = `MCU_MEM_WORDS * 4;

    logic setup;
    logic access;
    logic iram_hit;
    logic dram_hit;
    logic ctrl_hit;
    logic addr_err;
    logic mem_busy;
    logic pready_q;
    logic pslverr_q;
    logic ctrl_rd_q;
    logic ctrl_wr_q;
    logic fetch_en_q;

    assign setup  = psel_i && !penable_i;
    assign access = psel_i && penable_i;

    assign iram_hit = (paddr_i >= `MCU_IRAM_BASE) && (paddr_i < `MCU_IRAM_BASE + REGION_BYTES);
    assign dram_hit = (paddr_i >= `MCU_DRAM_BASE) && (paddr_i < `MCU_DRAM_BASE + REGION_BYTES);
    assign ctrl_hit = (paddr_i == `MCU_CTRL_ADDR);
    assign addr_err = !(iram_hit || dram_hit || ctrl_hit);
    // SRAMs belong to the core while it runs
    assign mem_busy = fetch_en_q && (iram_hit || dram_hit);

    // Single-cycle requests in the setup phase, always granted
    assign iram_req_o.req   = setup && iram_hit && !fetch_en_q;
    assign iram_req_o.we    = pwrite_i;
    assign iram_req_o.be    = '1;
    assign iram_req_o.addr  = paddr_i - `MCU_IRAM_BASE;
    assign iram_req_o.wdata = pwdata_i;

    assign dram_req_o.req   = setup && dram_hit && !fetch_en_q;
    assign dram_req_o.we    = pwrite_i;
    assign dram_req_o.be    = '1;
    assign dram_req_o.addr  = paddr_i - `MCU_DRAM_BASE;
    assign dram_req_o.wdata = pwdata_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pready_q   <= 1'b0;
            pslverr_q  <= 1'b0;
            ctrl_rd_q  <= 1'b0;
            ctrl_wr_q  <= 1'b0;
            fetch_en_q <= 1'b0;
        end else begin
            pready_q  <= setup;
            pslverr_q <= setup && (addr_err || mem_busy);
            ctrl_rd_q <= setup && ctrl_hit && !pwrite_i;
            ctrl_wr_q <= setup && ctrl_hit && pwrite_i;
            if (access && ctrl_wr_q) begin
                fetch_en_q <= pwdata_i[0];
            end
        end
    end

    // Read data lands in the access phase
    always_comb begin
        prdata_o = '0;
        if (iram_resp_i.rvalid) begin
            prdata_o = iram_resp_i.rdata;
        end else if (dram_resp_i.rvalid) begin
            prdata_o = dram_resp_i.rdata;
        end else if (ctrl_rd_q) begin
            prdata_o = {{(`MCU_DATA_W-1){1'b0}}, fetch_en_q};
        end
    end

    assign pready_o   = pready_q;
    assign pslverr_o  = pslverr_q;
    assign fetch_en_o = fetch_en_q;

    // Host requests are answered in time for the access phase
    a_host_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (iram_req_o.req || dram_req_o.req) |=> (iram_resp_i.rvalid || dram_resp_i.rvalid));

endmodule

// File: design/mcu_top.sv
// MCU top level
// APB bridge, CPU subsystem and the instruction and data SRAMs

`timescale 1ns/1ns
`include "mcu_defs.svh"

module mcu_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [`MCU_ADDR_W-1:0] paddr_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [`MCU_DATA_W-1:0] pwdata_i,
    output logic [`MCU_DATA_W-1:0] prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    input  logic [31:0]            irq_i,
    output logic [ 4:0]            irq_id_o,
    output logic                   irq_ack_o,
    output logic                   core_sleep_o
);

    mcu_pkg::obi_req_t  iram_host_req;
    mcu_pkg::obi_resp_t iram_host_resp;
    mcu_pkg::obi_req_t  dram_host_req;
    mcu_pkg::obi_resp_t dram_host_resp;
    mcu_pkg::obi_req_t  core_instr_req;
    mcu_pkg::obi_resp_t core_instr_resp;
    mcu_pkg::obi_req_t  core_data_req;
    mcu_pkg::obi_resp_t core_data_resp;
    logic               fetch_en;

    apb_mem_bridge i_bridge (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .paddr_i    (paddr_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .iram_req_o (iram_host_req),
        .iram_resp_i(iram_host_resp),
        .dram_req_o (dram_host_req),
        .dram_resp_i(dram_host_resp),
        .fetch_en_o (fetch_en)
    );

    cpu_subsystem i_cpu (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .fetch_en_i       (fetch_en),
        .core_instr_req_o (core_instr_req),
        .core_instr_resp_i(core_instr_resp),
        .core_data_req_o  (core_data_req),
        .core_data_resp_i (core_data_resp),
        .irq_i            (irq_i),
        .irq_ack_o        (irq_ack_o),
        .irq_id_o         (irq_id_o),
        .core_sleep_o     (core_sleep_o)
    );

    obi_sram i_iram (
        .clk_i      (clk_i),
        .host_req_i (iram_host_req),
        .host_resp_o(iram_host_resp),
        .core_req_i (core_instr_req),
        .core_resp_o(core_instr_resp)
    );

    obi_sram i_dram (
        .clk_i      (clk_i),
        .host_req_i (dram_host_req),
        .host_resp_o(dram_host_resp),
        .core_req_i (core_data_req),
        .core_resp_o(core_data_resp)
    );

endmodule

// File: verif/tb_checker.sv
// Testbench checker
// Watches the MCU top-level outputs, compares them with expected values, keeps error counts

`timescale 1ns/1ns

module tb_checker (
    input  logic        clk_i,
    input  logic [31:0] prdata_i,
    input  logic        pready_i,
    input  logic        pslverr_i,
    input  logic        irq_ack_i,
    input  logic [ 4:0] irq_id_i,
    input  logic        core_sleep_i
);

    int          value_errs = 0;
    int          other_errs = 0;
    int          ack_count  = 0;
    int          ack_base   = 0;
    logic [31:0] last_rdata = '0;
    logic        last_err   = 1'b0;
    logic [ 4:0] ack_id     = '0;

    // Capture the APB access phase and every acknowledge cycle
    always @(negedge clk_i) begin
        if (pready_i) begin
            last_rdata <= prdata_i;
            last_err   <= pslverr_i;
        end
        if (irq_ack_i) begin
            ack_count <= ack_count + 1;
            ack_id    <= irq_id_i;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // Data is only meaningful when no error is expected
    task automatic expect_read(input string name, input logic [31:0] exp_data,
                               input logic exp_err);
        check_value("pslverr_o", 32'(last_err), 32'(exp_err));
        if (!exp_err) begin
            check_value(name, last_rdata, exp_data);
        end
    endtask

    task automatic expect_sleep();
        check_value("core_sleep_o", 32'(core_sleep_i), 32'h1);
    endtask

    task automatic expect_irq(input int exp_count, input logic [4:0] exp_id);
        int seen;
        seen = ack_count - ack_base;
        if (seen != exp_count) begin
            other_errs++;
            $display("Expected %0d irq_ack_o pulse(s) but saw %0d", exp_count, seen);
        end
        if (exp_count > 0) begin
            check_value("irq_id_o", 32'(ack_id), 32'(exp_id));
            // Id stays put after the acknowledge
            check_value("irq_id_o", 32'(irq_id_i), 32'(exp_id));
        end
        ack_base = ack_count;
    endtask

    task automatic note_failure(input string what);
        other_errs++;
        $display("Failure: %s", what);
    endtask

endmodule

// File: verif/tb_top.sv
// MCU testbench
// Loads sum and countdown programs over APB, runs the core and checks results and interrupts

`timescale 1ns/1ns
`include "mcu_defs.svh"

module tb_top;

    typedef struct packed {
        logic        countdown;
        logic [15:0] op_a;
        logic [15:0] op_b;
        logic        raise_irq;
        logic [31:0] irq_bits;
        logic [ 4:0] exp_id;
        logic [31:0] exp_result;
    } row_t;

    localparam int          N_ROWS  = 6;
    localparam int          TIMEOUT = 5000;
    localparam logic [23:0] MARKER  = 24'hC0FFEE;

    logic        clk;
    logic        rst_n;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] irq;
    logic [ 4:0] irq_id;
    logic        irq_ack;
    logic        core_sleep;

    row_t        rows[N_ROWS];
    logic [31:0] prog[$];
    logic [31:0] seed;
    logic        hung;

    mcu_top i_dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .paddr_i     (paddr),
        .psel_i      (psel),
        .penable_i   (penable),
        .pwrite_i    (pwrite),
        .pwdata_i    (pwdata),
        .prdata_o    (prdata),
        .pready_o    (pready),
        .pslverr_o   (pslverr),
        .irq_i       (irq),
        .irq_id_o    (irq_id),
        .irq_ack_o   (irq_ack),
        .core_sleep_o(core_sleep)
    );

    tb_checker i_chk (
        .clk_i       (clk),
        .prdata_i    (prdata),
        .pready_i    (pready),
        .pslverr_i   (pslverr),
        .irq_ack_i   (irq_ack),
        .irq_id_i    (irq_id),
        .core_sleep_i(core_sleep)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // First set bit found scanning upward from bit 0
    function automatic logic [4:0] lowest_set(input logic [31:0] bits);
        logic [4:0] id;
        logic       found;
        id    = '0;
        found = 1'b0;
        for (int i = 0; i < 32; i++) begin
            if (bits[i] && !found) begin
                id    = 5'(i);
                found = 1'b1;
            end
        end
        return id;
    endfunction

    function automatic logic [31:0] instr(input mcu_pkg::opcode_e op, input logic [23:0] opnd);
        return {op, 4'h0, opnd};
    endfunction

    task automatic apb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] data);
        int cnt;
        if (hung) return;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!pready && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!pready) begin
            hung = 1'b1;
            i_chk.note_failure("APB slave never raised pready");
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        apb_xfer(1'b1, addr, data);
    endtask

    task automatic apb_read(input logic [31:0] addr);
        apb_xfer(1'b0, addr, 32'h0);
    endtask

    task automatic wait_sleep(input logic level);
        int cnt;
        if (hung) return;
        cnt = 0;
        @(negedge clk);
        while (core_sleep !== level && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (core_sleep !== level) begin
            hung = 1'b1;
            i_chk.note_failure("core_sleep_o did not reach the awaited level");
        end
    endtask

    task automatic wait_ack();
        int cnt;
        if (hung) return;
        cnt = 0;
        @(negedge clk);
        while (!irq_ack && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!irq_ack) begin
            hung = 1'b1;
            i_chk.note_failure("core never acknowledged the interrupt");
        end
    endtask

    task automatic load_program(input row_t row);
        logic [23:0] n;
        prog.delete();
        if (row.countdown) begin
            n = 24'(row.op_a[3:0]) + 24'd1;
            prog.push_back(instr(mcu_pkg::LDI, n));
            prog.push_back(instr(mcu_pkg::ST, 24'h10));
            // Loop body at 0x08, total at 0x08, step at 0x04, counter at 0x10
            prog.push_back(instr(mcu_pkg::LD, 24'h08));
            prog.push_back(instr(mcu_pkg::ADD, 24'h04));
            prog.push_back(instr(mcu_pkg::ST, 24'h08));
            prog.push_back(instr(mcu_pkg::LD, 24'h10));
            prog.push_back(instr(mcu_pkg::DEC, 24'h0));
            prog.push_back(instr(mcu_pkg::ST, 24'h10));
            prog.push_back(instr(mcu_pkg::BNZ, 24'h08));
        end else begin
            prog.push_back(instr(mcu_pkg::LD, 24'h00));
            prog.push_back(instr(mcu_pkg::ADD, 24'h04));
            prog.push_back(instr(mcu_pkg::ST, 24'h08));
        end
        prog.push_back(instr(mcu_pkg::HALT, 24'h0));
        prog.push_back(instr(mcu_pkg::HALT, 24'h0));
        foreach (prog[i]) begin
            apb_write(`MCU_IRAM_BASE + 32'(4 * i), prog[i]);
        end
        // Interrupt routine writes the marker word
        apb_write(`MCU_IRAM_BASE + `MCU_IRQ_VECTOR, instr(mcu_pkg::LDI, MARKER));
        apb_write(`MCU_IRAM_BASE + `MCU_IRQ_VECTOR + 32'h4, instr(mcu_pkg::ST, 24'h0C));
        apb_write(`MCU_IRAM_BASE + `MCU_IRQ_VECTOR + 32'h8, instr(mcu_pkg::RETI, 24'h0));
    endtask

    task automatic run_row(input row_t row);
        apb_write(`MCU_CTRL_ADDR, 32'h0);
        load_program(row);
        apb_write(`MCU_DRAM_BASE + 32'h00, 32'(row.op_a));
        apb_write(`MCU_DRAM_BASE + 32'h04, 32'(row.op_b));
        apb_write(`MCU_DRAM_BASE + 32'h08, 32'h0);
        apb_write(`MCU_DRAM_BASE + 32'h0C, 32'h0);
        apb_write(`MCU_CTRL_ADDR, 32'h1);
        wait_sleep(1'b1);
        repeat (4) @(negedge clk);
        i_chk.expect_sleep();
        // Memory is locked while the core owns it
        apb_read(`MCU_DRAM_BASE);
        i_chk.expect_read("prdata_o", 32'h0, 1'b1);
        if (row.raise_irq) begin
            @(posedge clk);
            irq <= row.irq_bits;
            wait_ack();
            @(posedge clk);
            irq <= '0;
            wait_sleep(1'b1);
            i_chk.expect_irq(1, row.exp_id);
        end else begin
            i_chk.expect_irq(0, 5'h0);
        end
        apb_write(`MCU_CTRL_ADDR, 32'h0);
        apb_read(`MCU_DRAM_BASE + 32'h08);
        i_chk.expect_read("result", row.exp_result, 1'b0);
        apb_read(`MCU_DRAM_BASE + 32'h0C);
        i_chk.expect_read("marker", row.raise_irq ? 32'(MARKER) : 32'h0, 1'b0);
    endtask

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        irq     = '0;
        hung    = 1'b0;
        seed    = 32'ha36bd72a;

        // Alternating sum and countdown rows, interrupts on half of them
        for (int r = 0; r < N_ROWS; r++) begin
            rows[r].countdown = r[0];
            rows[r].raise_irq = r[1] ^ r[0];
            seed = xorshift32(seed);
            rows[r].op_a = seed[15:0];
            seed = xorshift32(seed);
            rows[r].op_b = seed[15:0];
            rows[r].irq_bits = '0;
            while (rows[r].irq_bits == '0) begin
                seed = xorshift32(seed);
                rows[r].irq_bits = seed & xorshift32(seed);
            end
            rows[r].exp_id = lowest_set(rows[r].irq_bits);
            if (rows[r].countdown) begin
                rows[r].exp_result = (32'(rows[r].op_a[3:0]) + 32'd1) * 32'(rows[r].op_b);
            end else begin
                rows[r].exp_result = 32'(rows[r].op_a) + 32'(rows[r].op_b);
            end
        end

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        apb_write(`MCU_DRAM_BASE + 32'h20, 32'h5A5A_1234);
        apb_read(`MCU_DRAM_BASE + 32'h20);
        i_chk.expect_read("prdata_o", 32'h5A5A_1234, 1'b0);
        apb_read(32'h0000_0300);
        i_chk.expect_read("prdata_o", 32'h0, 1'b1);

        for (int r = 0; r < N_ROWS; r++) begin
            run_row(rows[r]);
        end

        repeat (2) @(posedge clk);
        $display("Checks done: %0d value errors, %0d other errors",
                 i_chk.value_errs, i_chk.other_errs);
        if (i_chk.value_errs == 0 && i_chk.other_errs == 0 && !hung) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+design
design/mcu_pkg.sv
design/acc_core.sv
design/cpu_subsystem.sv
design/obi_sram.sv
design/apb_mem_bridge.sv
design/mcu_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -f build.f --top-module tb_top -o tb_sim \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -qx "Test passed" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
